/* csr_access.sv */
`timescale 1ns/1ps
`default_nettype none
`include "csr_macros.svh"

module csr_access (
    input  csr_pkg::csr_addr_e    csr_addr_i,
    input  csr_pkg::csr_op_e      csr_op_i,
    input  logic [`CSR_XLEN-1:0]  csr_wdata_i,
    input  logic                  csr_op_en_i,
    input  logic                  trap_i,
    input  csr_pkg::cfg_t         cfg_i,
    input  csr_pkg::trap_state_t  state_i,
    input  csr_pkg::irq_lines_t   irq_i,
    output logic [`CSR_XLEN-1:0]  csr_rdata_o,
    output csr_pkg::csr_wr_t      wr_o
);

    csr_pkg::status_t      st;
    logic                  sd;
    logic [`CSR_XLEN-1:0]  mstatus;
    logic [`CSR_XLEN-1:0]  sstatus;
    logic [`CSR_XLEN-1:0]  old_value;
    logic [`CSR_XLEN-1:0]  new_value;
    logic [`CSR_IRQ_W-1:0] mip;
    logic [`CSR_IRQ_W-1:0] sei_line;

    assign st = state_i.status;
    assign sd = &st.fs;

    // SXL and UXL hardwired to 64 bits
    assign mstatus = {
        sd, 27'b0, 2'b10, 2'b10, 9'b0, st.tsr, st.tw, st.tvm, st.mxr, st.sum, st.mprv,
        2'b0, st.fs, st.mpp, 2'b0, st.spp, st.mpie, 1'b0, st.spie, 1'b0, st.mie, 1'b0,
        st.sie, 1'b0
    };
    assign sstatus = {
        sd, 29'b0, 2'b10, 12'b0, st.mxr, st.sum, 3'b0, st.fs, 4'b0, st.spp, 2'b0,
        st.spie, 3'b0, st.sie, 1'b0
    };

    always_comb begin
        mip = '0;
        mip[`CSR_BIT_MEI] = irq_i.m_external;
        mip[`CSR_BIT_MTI] = irq_i.m_timer;
        mip[`CSR_BIT_MSI] = irq_i.m_software;
        mip[`CSR_BIT_SEI] = cfg_i.seip;
        mip[`CSR_BIT_STI] = cfg_i.stip;
        mip[`CSR_BIT_SSI] = cfg_i.ssip;
        // External S-level line is visible on reads but never stored
        sei_line = '0;
        sei_line[`CSR_BIT_SEI] = irq_i.s_external;
    end

    // Read multiplexer
    always_comb begin
        case (csr_addr_i)
            csr_pkg::CSR_SSTATUS:  old_value = sstatus;
            csr_pkg::CSR_SIE:      old_value = `CSR_XLEN'(cfg_i.mie & cfg_i.mideleg);
            csr_pkg::CSR_STVEC:    old_value = cfg_i.stvec;
            csr_pkg::CSR_SSCRATCH: old_value = cfg_i.sscratch;
            csr_pkg::CSR_SEPC:     old_value = state_i.sepc;
            csr_pkg::CSR_SCAUSE:   old_value = {state_i.scause_irq, 59'b0, state_i.scause_code};
            csr_pkg::CSR_STVAL:    old_value = state_i.stval;
            csr_pkg::CSR_SIP:      old_value = `CSR_XLEN'(mip & cfg_i.mideleg);
            csr_pkg::CSR_MSTATUS:  old_value = mstatus;
            csr_pkg::CSR_MISA:     old_value = `CSR_MISA_VALUE;
            csr_pkg::CSR_MEDELEG:  old_value = `CSR_XLEN'(cfg_i.medeleg);
            csr_pkg::CSR_MIDELEG:  old_value = `CSR_XLEN'(cfg_i.mideleg);
            csr_pkg::CSR_MIE:      old_value = `CSR_XLEN'(cfg_i.mie);
            csr_pkg::CSR_MTVEC:    old_value = cfg_i.mtvec;
            csr_pkg::CSR_MSCRATCH: old_value = cfg_i.mscratch;
            csr_pkg::CSR_MEPC:     old_value = state_i.mepc;
            csr_pkg::CSR_MCAUSE:   old_value = {state_i.mcause_irq, 59'b0, state_i.mcause_code};
            csr_pkg::CSR_MTVAL:    old_value = state_i.mtval;
            csr_pkg::CSR_MIP:      old_value = `CSR_XLEN'(mip);
            // IDs and hart ID read zero
            default:               old_value = '0;
        endcase

        csr_rdata_o = old_value;
        if (csr_addr_i == csr_pkg::CSR_MIP) begin
            csr_rdata_o = old_value | `CSR_XLEN'(sei_line);
        end else if (csr_addr_i == csr_pkg::CSR_SIP) begin
            csr_rdata_o = old_value | `CSR_XLEN'(sei_line & cfg_i.mideleg);
        end
    end

    // Read-modify-write
    always_comb begin
        case (csr_op_i)
            csr_pkg::CSR_OP_WRITE: new_value = csr_wdata_i;
            csr_pkg::CSR_OP_SET:   new_value = old_value | csr_wdata_i;
            csr_pkg::CSR_OP_CLEAR: new_value = old_value & ~csr_wdata_i;
            default:               new_value = old_value;
        endcase
    end

    // A trap in the same cycle always wins over the CSR write
    always_comb begin
        wr_o = '0;
        wr_o.data = new_value;
        if (csr_op_en_i && csr_op_i != csr_pkg::CSR_OP_READ && !trap_i) begin
            case (csr_addr_i)
                csr_pkg::CSR_SSTATUS:  wr_o.sstatus = 1'b1;
                csr_pkg::CSR_SIE:      wr_o.sie = 1'b1;
                csr_pkg::CSR_STVEC:    wr_o.stvec = 1'b1;
                csr_pkg::CSR_SSCRATCH: wr_o.sscratch = 1'b1;
                csr_pkg::CSR_SEPC:     wr_o.sepc = 1'b1;
                csr_pkg::CSR_SCAUSE:   wr_o.scause = 1'b1;
                csr_pkg::CSR_STVAL:    wr_o.stval = 1'b1;
                csr_pkg::CSR_SIP:      wr_o.sip = 1'b1;
                csr_pkg::CSR_MSTATUS:  wr_o.mstatus = 1'b1;
                csr_pkg::CSR_MEDELEG:  wr_o.medeleg = 1'b1;
                csr_pkg::CSR_MIDELEG:  wr_o.mideleg = 1'b1;
                csr_pkg::CSR_MIE:      wr_o.mie = 1'b1;
                csr_pkg::CSR_MTVEC:    wr_o.mtvec = 1'b1;
                csr_pkg::CSR_MSCRATCH: wr_o.mscratch = 1'b1;
                csr_pkg::CSR_MEPC:     wr_o.mepc = 1'b1;
                csr_pkg::CSR_MCAUSE:   wr_o.mcause = 1'b1;
                csr_pkg::CSR_MTVAL:    wr_o.mtval = 1'b1;
                csr_pkg::CSR_MIP:      wr_o.mip = 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* csr_cases.txt */
# name kind f1 f2 f3 expected in hex. csr = op addr wdata and rdata, exception = cause tval epc and tvec
# return = prv 0 0 and epc, irq = lines 0 0 and the nibbles prv wfi int_valid int_cause
reset_irq irq 0 0 0 3000
reset_mstatus csr 0 300 0 a00000000
reset_mie csr 0 304 0 0
reset_mepc csr 0 341 0 0
reset_mhartid csr 0 f14 0 0
reset_mip csr 0 344 0 0
warl_mie_wr csr 1 304 ffffffffffffffff 0
warl_mie_rd csr 0 304 0 aaa
warl_mideleg_wr csr 1 303 ffffffffffffffff 0
warl_mideleg_rd csr 0 303 0 222
warl_medeleg_wr csr 1 302 ffffffffffffffff 0
warl_medeleg_rd csr 0 302 0 b35d
warl_mtvec_wr csr 1 305 ffffffffffffffff 0
warl_mtvec_rd csr 0 305 0 fffffffffffffffc
warl_mepc_wr csr 1 341 ffffffffffffffff 0
warl_mepc_rd csr 0 341 0 fffffffffffffffe
warl_misa_wr csr 1 301 0 8000000000141105
warl_misa_rd csr 0 301 0 8000000000141105
sc_mscratch_wr csr 1 340 f0 0
sc_mscratch_set csr 2 340 f00 f0
sc_mscratch_clr csr 3 340 30 ff0
sc_mscratch_rd csr 0 340 0 fc0
sc_sstatus_set csr 2 100 40022 200000000
sc_sstatus_clr csr 3 100 2 200040022
sc_mstatus_rd csr 0 300 0 a00040020
exc_mtvec_wr csr 1 305 1000 fffffffffffffffc
exc_mie_set csr 2 300 8 a00040020
exc_m_mode exception 2 bad0 2000 1000
exc_mepc_rd csr 0 341 0 2000
exc_mcause_rd csr 0 342 0 2
exc_mtval_rd csr 0 343 0 bad0
exc_mstatus_rd csr 0 300 0 a000418a0
exc_prv_m irq 0 0 0 3000
del_stvec_wr csr 1 105 3000 0
del_mpp_wr csr 1 300 800 a000418a0
del_mepc_wr csr 1 341 4001 2000
del_mret return 3 0 0 4000
del_exc_s exception 2 cafe 5000 3000
del_sepc_rd csr 0 141 0 5000
del_scause_rd csr 0 142 0 2
del_stval_rd csr 0 143 0 cafe
del_prv_s irq 0 0 0 1000
del_spp_clr csr 3 100 100 200000100
del_sret return 1 0 0 5000
del_prv_u irq 0 0 0 0
irq_to_m exception 1 0 6000 1000
irq_mie_set csr 2 300 8 a00000020
irq_msi_mti irq 6 0 0 3113
irq_mti irq 2 0 0 3117
irq_mie_clr csr 3 300 8 a00000028
irq_masked irq 2 0 0 3100
irq_idle irq 0 0 0 3000

/* csr_config_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "csr_macros.svh"

module csr_config_regs (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  csr_pkg::csr_wr_t  wr_i,
    output csr_pkg::cfg_t     cfg_o,
    output csr_pkg::cfg_t     cfg_next_o
);

    csr_pkg::cfg_t        cfg_q;
    csr_pkg::cfg_t        cfg_d;
    logic [`CSR_XLEN-1:0] v;

    assign v = wr_i.data;

    always_comb begin
        cfg_d = cfg_q;
        if (wr_i.mie) cfg_d.mie = v[`CSR_IRQ_W-1:0] & `CSR_MIE_MASK;
        // Only delegated bits are reachable through sie
        if (wr_i.sie) begin
            cfg_d.mie = (cfg_q.mie & ~cfg_q.mideleg) | (v[`CSR_IRQ_W-1:0] & cfg_q.mideleg);
        end
        if (wr_i.mideleg) cfg_d.mideleg = v[`CSR_IRQ_W-1:0] & `CSR_MIDELEG_MASK;
        if (wr_i.medeleg) cfg_d.medeleg = v[15:0] & `CSR_MEDELEG_MASK;
        // Direct mode only
        if (wr_i.mtvec) cfg_d.mtvec = {v[`CSR_XLEN-1:2], 2'b0};
        if (wr_i.stvec) cfg_d.stvec = {v[`CSR_XLEN-1:2], 2'b0};
        if (wr_i.mscratch) cfg_d.mscratch = v;
        if (wr_i.sscratch) cfg_d.sscratch = v;
        if (wr_i.sip && cfg_q.mideleg[`CSR_BIT_SSI]) cfg_d.ssip = v[`CSR_BIT_SSI];
        if (wr_i.mip) begin
            cfg_d.seip = v[`CSR_BIT_SEI];
            cfg_d.stip = v[`CSR_BIT_STI];
            cfg_d.ssip = v[`CSR_BIT_SSI];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cfg_q <= '0;
        end else begin
            cfg_q <= cfg_d;
        end
    end

    assign cfg_o      = cfg_q;
    assign cfg_next_o = cfg_d;

endmodule

`default_nettype wire

/* csr_file_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "csr_macros.svh"

module csr_file_top (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  csr_pkg::csr_addr_e   csr_addr_i,
    input  logic [`CSR_XLEN-1:0] csr_wdata_i,
    input  csr_pkg::csr_op_e     csr_op_i,
    input  logic                 csr_op_en_i,
    output logic [`CSR_XLEN-1:0] csr_rdata_o,
    input  logic                 ex_valid_i,
    input  csr_pkg::exc_req_t    ex_i,
    output logic [`CSR_XLEN-1:0] ex_tvec_o,
    input  logic                 er_valid_i,
    input  csr_pkg::priv_lvl_e   er_prv_i,
    output logic [`CSR_XLEN-1:0] er_epc_o,
    input  csr_pkg::irq_lines_t  irq_i,
    output csr_pkg::priv_lvl_e   priv_mode_o,
    output csr_pkg::priv_lvl_e   priv_mode_lsu_o,
    output logic                 int_valid_o,
    output logic [3:0]           int_cause_o,
    output logic                 wfi_valid_o,
    output csr_pkg::status_t     status_o
);

    csr_pkg::cfg_t        cfg;
    csr_pkg::cfg_t        cfg_next;
    csr_pkg::trap_state_t state;
    csr_pkg::csr_wr_t     wr;
    csr_pkg::priv_lvl_e   prv_next;
    csr_pkg::status_t     status_next;

    assign priv_mode_o = state.prv;
    assign status_o    = state.status;

    csr_access i_csr_access (
        .csr_addr_i  (csr_addr_i),
        .csr_op_i    (csr_op_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_op_en_i (csr_op_en_i),
        .trap_i      (ex_valid_i | er_valid_i),
        .cfg_i       (cfg),
        .state_i     (state),
        .irq_i       (irq_i),
        .csr_rdata_o (csr_rdata_o),
        .wr_o        (wr)
    );

    csr_config_regs i_csr_config_regs (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .wr_i       (wr),
        .cfg_o      (cfg),
        .cfg_next_o (cfg_next)
    );

    csr_trap_unit i_csr_trap_unit (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .ex_valid_i      (ex_valid_i),
        .ex_i            (ex_i),
        .er_valid_i      (er_valid_i),
        .er_prv_i        (er_prv_i),
        .wr_i            (wr),
        .cfg_i           (cfg),
        .state_o         (state),
        .prv_next_o      (prv_next),
        .status_next_o   (status_next),
        .ex_tvec_o       (ex_tvec_o),
        .er_epc_o        (er_epc_o),
        .priv_mode_lsu_o (priv_mode_lsu_o)
    );

    csr_irq_ctrl i_csr_irq_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .irq_i         (irq_i),
        .cfg_next_i    (cfg_next),
        .prv_next_i    (prv_next),
        .status_next_i (status_next),
        .int_valid_o   (int_valid_o),
        .int_cause_o   (int_cause_o),
        .wfi_valid_o   (wfi_valid_o)
    );

endmodule

`default_nettype wire

/* csr_irq_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "csr_macros.svh"

module csr_irq_ctrl (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  csr_pkg::irq_lines_t  irq_i,
    input  csr_pkg::cfg_t        cfg_next_i,
    input  csr_pkg::priv_lvl_e   prv_next_i,
    input  csr_pkg::status_t     status_next_i,
    output logic                 int_valid_o,
    output logic [3:0]           int_cause_o,
    output logic                 wfi_valid_o
);

    logic [`CSR_IRQ_W-1:0] irq_high;
    logic [`CSR_IRQ_W-1:0] irq_en;
    logic [`CSR_IRQ_W-1:0] pend_d;
    logic [`CSR_IRQ_W-1:0] pend_q;
    logic                  m_on;
    logic                  s_on;

    always_comb begin
        irq_high = '0;
        irq_high[`CSR_BIT_MEI] = irq_i.m_external;
        irq_high[`CSR_BIT_MSI] = irq_i.m_software;
        irq_high[`CSR_BIT_MTI] = irq_i.m_timer;
        irq_high[`CSR_BIT_SEI] = irq_i.s_external | cfg_next_i.seip;
        irq_high[`CSR_BIT_STI] = cfg_next_i.stip;
        irq_high[`CSR_BIT_SSI] = cfg_next_i.ssip;
        irq_en = irq_high & cfg_next_i.mie;

        // Global enables, seen from the mode after this cycle
        m_on = (prv_next_i != csr_pkg::PRIV_LVL_M) || status_next_i.mie;
        s_on = (prv_next_i == csr_pkg::PRIV_LVL_U) ||
               (prv_next_i == csr_pkg::PRIV_LVL_S && status_next_i.sie);
        pend_d = ({`CSR_IRQ_W{m_on}} & irq_en & ~cfg_next_i.mideleg) |
                 ({`CSR_IRQ_W{s_on}} & irq_en & cfg_next_i.mideleg);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pend_q      <= '0;
            wfi_valid_o <= 1'b0;
        end else begin
            pend_q      <= pend_d;
            wfi_valid_o <= |irq_en;
        end
    end

    assign int_valid_o = |pend_q;

    // MEI > MSI > MTI > SEI > SSI > STI
    always_comb begin
        if (pend_q[`CSR_BIT_MEI])      int_cause_o = 4'(`CSR_BIT_MEI);
        else if (pend_q[`CSR_BIT_MSI]) int_cause_o = 4'(`CSR_BIT_MSI);
        else if (pend_q[`CSR_BIT_MTI]) int_cause_o = 4'(`CSR_BIT_MTI);
        else if (pend_q[`CSR_BIT_SEI]) int_cause_o = 4'(`CSR_BIT_SEI);
        else if (pend_q[`CSR_BIT_SSI]) int_cause_o = 4'(`CSR_BIT_SSI);
        else if (pend_q[`CSR_BIT_STI]) int_cause_o = 4'(`CSR_BIT_STI);
        else                           int_cause_o = '0;
    end

endmodule

`default_nettype wire

/* csr_macros.svh */
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// Data path width
`define CSR_XLEN 64

// WARL masks for the trap setup registers
`define CSR_MIE_MASK 12'hAAA
`define CSR_MIDELEG_MASK 12'h222
`define CSR_MEDELEG_MASK 16'hB35D

// Interrupt vector width and bit positions
`define CSR_IRQ_W 12
`define CSR_BIT_MEI 11
`define CSR_BIT_SEI 9
`define CSR_BIT_MTI 7
`define CSR_BIT_STI 5
`define CSR_BIT_MSI 3
`define CSR_BIT_SSI 1

// MXL = 2, extensions A, C, I, M, S and U
`define CSR_MISA_VALUE 64'h8000_0000_0014_1105

`endif

/* csr_pkg.sv */
`default_nettype none
`include "csr_macros.svh"

package csr_pkg;

    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'b00,
        PRIV_LVL_S = 2'b01,
        PRIV_LVL_M = 2'b11
    } priv_lvl_e;

    typedef enum logic [1:0] {
        CSR_OP_READ  = 2'b00,
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_e;

    // Only the CSRs kept in this hart
    typedef enum logic [11:0] {
        CSR_SSTATUS   = 12'h100,
        CSR_SIE       = 12'h104,
        CSR_STVEC     = 12'h105,
        CSR_SSCRATCH  = 12'h140,
        CSR_SEPC      = 12'h141,
        CSR_SCAUSE    = 12'h142,
        CSR_STVAL     = 12'h143,
        CSR_SIP       = 12'h144,
        CSR_MSTATUS   = 12'h300,
        CSR_MISA      = 12'h301,
        CSR_MEDELEG   = 12'h302,
        CSR_MIDELEG   = 12'h303,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MTVAL     = 12'h343,
        CSR_MIP       = 12'h344,
        CSR_MVENDORID = 12'hF11,
        CSR_MARCHID   = 12'hF12,
        CSR_MIMPID    = 12'hF13,
        CSR_MHARTID   = 12'hF14
    } csr_addr_e;

    typedef struct packed {
        logic      tsr;
        logic      tw;
        logic      tvm;
        logic      mxr;
        logic      sum;
        logic      mprv;
        logic [1:0] fs;
        priv_lvl_e mpp;
        logic      spp;
        logic      mpie;
        logic      spie;
        logic      mie;
        logic      sie;
    } status_t;

    // One strobe per register group, plus the value to write
    typedef struct packed {
        logic mstatus;
        logic sstatus;
        logic mie;
        logic sie;
        logic mideleg;
        logic medeleg;
        logic mtvec;
        logic stvec;
        logic mscratch;
        logic sscratch;
        logic mepc;
        logic sepc;
        logic mcause;
        logic scause;
        logic mtval;
        logic stval;
        logic mip;
        logic sip;
        logic [`CSR_XLEN-1:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic [`CSR_IRQ_W-1:0] mie;
        logic [`CSR_IRQ_W-1:0] mideleg;
        logic [15:0]           medeleg;
        logic [`CSR_XLEN-1:0]  mtvec;
        logic [`CSR_XLEN-1:0]  stvec;
        logic [`CSR_XLEN-1:0]  mscratch;
        logic [`CSR_XLEN-1:0]  sscratch;
        logic                  seip;
        logic                  stip;
        logic                  ssip;
    } cfg_t;

    typedef struct packed {
        priv_lvl_e            prv;
        status_t              status;
        logic [`CSR_XLEN-1:0] mepc;
        logic [`CSR_XLEN-1:0] sepc;
        logic                 mcause_irq;
        logic [3:0]           mcause_code;
        logic                 scause_irq;
        logic [3:0]           scause_code;
        logic [`CSR_XLEN-1:0] mtval;
        logic [`CSR_XLEN-1:0] stval;
    } trap_state_t;

    typedef struct packed {
        logic                 irq;
        logic [3:0]           code;
        logic [`CSR_XLEN-1:0] tval;
        logic [`CSR_XLEN-1:0] epc;
    } exc_req_t;

    typedef struct packed {
        logic m_external;
        logic m_software;
        logic m_timer;
        logic s_external;
    } irq_lines_t;

endpackage

`default_nettype wire

/* csr_trap_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "csr_macros.svh"

module csr_trap_unit (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  ex_valid_i,
    input  csr_pkg::exc_req_t     ex_i,
    input  logic                  er_valid_i,
    input  csr_pkg::priv_lvl_e    er_prv_i,
    input  csr_pkg::csr_wr_t      wr_i,
    input  csr_pkg::cfg_t         cfg_i,
    output csr_pkg::trap_state_t  state_o,
    output csr_pkg::priv_lvl_e    prv_next_o,
    output csr_pkg::status_t      status_next_o,
    output logic [`CSR_XLEN-1:0]  ex_tvec_o,
    output logic [`CSR_XLEN-1:0]  er_epc_o,
    output csr_pkg::priv_lvl_e    priv_mode_lsu_o
);

    csr_pkg::trap_state_t q;
    csr_pkg::trap_state_t d;
    logic [15:0]          ideleg;
    logic                 deleg;
    logic [`CSR_XLEN-1:0] v;

    assign v      = wr_i.data;
    assign ideleg = 16'(cfg_i.mideleg);
    // Traps from S or U go to S when the cause is delegated
    assign deleg  = (q.prv != csr_pkg::PRIV_LVL_M) &&
                    (ex_i.irq ? ideleg[ex_i.code] : cfg_i.medeleg[ex_i.code]);

    always_comb begin
        d         = q;
        ex_tvec_o = '0;
        er_epc_o  = '0;

        if (ex_valid_i) begin
            if (deleg) begin
                ex_tvec_o        = cfg_i.stvec;
                d.scause_irq     = ex_i.irq;
                d.scause_code    = ex_i.code;
                d.stval          = ex_i.tval;
                d.sepc           = ex_i.epc;
                d.prv            = csr_pkg::PRIV_LVL_S;
                d.status.sie     = 1'b0;
                d.status.spie    = q.status.sie;
                d.status.spp     = q.prv[0];
            end else begin
                ex_tvec_o        = cfg_i.mtvec;
                d.mcause_irq     = ex_i.irq;
                d.mcause_code    = ex_i.code;
                d.mtval          = ex_i.tval;
                d.mepc           = ex_i.epc;
                d.prv            = csr_pkg::PRIV_LVL_M;
                d.status.mie     = 1'b0;
                d.status.mpie    = q.status.mie;
                d.status.mpp     = q.prv;
            end
        end else if (er_valid_i) begin
            if (er_prv_i != csr_pkg::PRIV_LVL_M) begin
                // sret
                er_epc_o      = q.sepc;
                d.prv         = q.status.spp ? csr_pkg::PRIV_LVL_S : csr_pkg::PRIV_LVL_U;
                d.status.sie  = q.status.spie;
                d.status.spie = 1'b1;
                d.status.spp  = 1'b0;
            end else begin
                // mret
                er_epc_o      = q.mepc;
                d.prv         = q.status.mpp;
                d.status.mie  = q.status.mpie;
                d.status.mpie = 1'b1;
                d.status.mpp  = csr_pkg::PRIV_LVL_U;
                if (q.status.mpp != csr_pkg::PRIV_LVL_M) d.status.mprv = 1'b0;
            end
        end

        // CSR writes, never active together with a trap
        if (wr_i.mstatus) begin
            d.status.tsr  = v[22];
            d.status.tw   = v[21];
            d.status.tvm  = v[20];
            d.status.mxr  = v[19];
            d.status.sum  = v[18];
            d.status.mprv = v[17];
            d.status.fs   = v[14:13];
            // No H mode, so MPP=2 is ignored
            if (v[12:11] != 2'b10) d.status.mpp = csr_pkg::priv_lvl_e'(v[12:11]);
            d.status.spp  = v[8];
            d.status.mpie = v[7];
            d.status.spie = v[5];
            d.status.mie  = v[3];
            d.status.sie  = v[1];
        end
        if (wr_i.sstatus) begin
            d.status.mxr  = v[19];
            d.status.sum  = v[18];
            d.status.fs   = v[14:13];
            d.status.spp  = v[8];
            d.status.spie = v[5];
            d.status.sie  = v[1];
        end
        if (wr_i.mepc) d.mepc = {v[`CSR_XLEN-1:1], 1'b0};
        if (wr_i.sepc) d.sepc = {v[`CSR_XLEN-1:1], 1'b0};
        if (wr_i.mcause) begin
            d.mcause_irq  = v[`CSR_XLEN-1];
            d.mcause_code = v[3:0];
        end
        if (wr_i.scause) begin
            d.scause_irq  = v[`CSR_XLEN-1];
            d.scause_code = v[3:0];
        end
        if (wr_i.mtval) d.mtval = v;
        if (wr_i.stval) d.stval = v;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            q     <= '0;
            q.prv <= csr_pkg::PRIV_LVL_M;
        end else begin
            q <= d;
        end
    end

    assign state_o         = q;
    assign prv_next_o      = d.prv;
    assign status_next_o   = d.status;
    // Loads and stores use MPP while MPRV is set
    assign priv_mode_lsu_o = q.status.mprv ? q.status.mpp : q.prv;

endmodule

`default_nettype wire

/* list.f */
+incdir+.
csr_pkg.sv
csr_access.sv
csr_config_regs.sv
csr_trap_unit.sv
csr_irq_ctrl.sv
csr_file_top.sv
tb_csr_file.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_csr_file \
    -f list.f && ./obj_dir/Vtb_csr_file)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'NO ERRORS' && echo 'Simulation passed' || { echo 'Simulation failed'; exit 1; }

/* tb_csr_file.sv */
`timescale 1ns/1ps
`default_nettype none
`include "csr_macros.svh"

module tb_csr_file;

    localparam int TOKEN_W         = 256;
    localparam int LINE_W          = 8 * 256;
    localparam int CYCLES_PER_CASE = 20;

    logic                  clk_i;
    logic                  rst_ni;
    csr_pkg::csr_addr_e    csr_addr;
    logic [`CSR_XLEN-1:0]  csr_wdata;
    csr_pkg::csr_op_e      csr_op;
    logic                  csr_op_en;
    logic [`CSR_XLEN-1:0]  csr_rdata;
    logic                  ex_valid;
    csr_pkg::exc_req_t     ex_req;
    logic [`CSR_XLEN-1:0]  ex_tvec;
    logic                  er_valid;
    csr_pkg::priv_lvl_e    er_prv;
    logic [`CSR_XLEN-1:0]  er_epc;
    csr_pkg::irq_lines_t   irq_lines;
    csr_pkg::priv_lvl_e    priv_mode;
    csr_pkg::priv_lvl_e    priv_mode_lsu;
    logic                  int_valid;
    logic [3:0]            int_cause;
    logic                  wfi_valid;
    csr_pkg::status_t      status;

    // Case file parsing
    int                    fd;
    int                    n;
    int                    line_count;
    logic                  done;
    logic [TOKEN_W-1:0]    name;
    logic [TOKEN_W-1:0]    kind;
    logic [LINE_W-1:0]     line_buf;
    logic [63:0]           f1;
    logic [63:0]           f2;
    logic [63:0]           f3;
    logic [63:0]           expected;

    int cycle_count = 0;
    int cycle_limit = 0;
    int check_count = 0;

    csr_file_top i_csr_file_top (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .csr_addr_i      (csr_addr),
        .csr_wdata_i     (csr_wdata),
        .csr_op_i        (csr_op),
        .csr_op_en_i     (csr_op_en),
        .csr_rdata_o     (csr_rdata),
        .ex_valid_i      (ex_valid),
        .ex_i            (ex_req),
        .ex_tvec_o       (ex_tvec),
        .er_valid_i      (er_valid),
        .er_prv_i        (er_prv),
        .er_epc_o        (er_epc),
        .irq_i           (irq_lines),
        .priv_mode_o     (priv_mode),
        .priv_mode_lsu_o (priv_mode_lsu),
        .int_valid_o     (int_valid),
        .int_cause_o     (int_cause),
        .wfi_valid_o     (wfi_valid),
        .status_o        (status)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // Watchdog sized from the case file length
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the case file did not finish", cycle_count);
            $display("ERRORS FOUND");
            $fatal(1, "Simulation timed out");
        end
    end

    task automatic check_value(input logic [TOKEN_W-1:0] case_name,
                               input logic [63:0] exp_value,
                               input logic [63:0] act_value);
        check_count = check_count + 1;
        assert (act_value === exp_value) else begin
            $display("ERROR %0s expected %h actual %h", case_name, exp_value, act_value);
            $display("ERRORS FOUND");
            $fatal(1, "Mismatch in case %0s", case_name);
        end
    endtask

    // Status fields at their mstatus bit positions
    function automatic csr_pkg::status_t status_from_mstatus(input logic [63:0] m);
        csr_pkg::status_t s;
        s.tsr  = m[22];
        s.tw   = m[21];
        s.tvm  = m[20];
        s.mxr  = m[19];
        s.sum  = m[18];
        s.mprv = m[17];
        s.fs   = m[14:13];
        s.mpp  = csr_pkg::priv_lvl_e'(m[12:11]);
        s.spp  = m[8];
        s.mpie = m[7];
        s.spie = m[5];
        s.mie  = m[3];
        s.sie  = m[1];
        return s;
    endfunction

    task automatic drive_idle();
        csr_op_en = 1'b0;
        csr_op    = csr_pkg::CSR_OP_READ;
        ex_valid  = 1'b0;
        er_valid  = 1'b0;
    endtask

    // Read data is the old value, also during a write
    task automatic run_csr_case(input logic [TOKEN_W-1:0] case_name, input logic [63:0] op,
                                input logic [63:0] addr, input logic [63:0] wdata,
                                input logic [63:0] exp_value);
        @(posedge clk_i);
        #1;
        drive_idle();
        csr_op    = csr_pkg::csr_op_e'(op[1:0]);
        csr_addr  = csr_pkg::csr_addr_e'(addr[11:0]);
        csr_wdata = wdata;
        csr_op_en = 1'b1;
        @(negedge clk_i);
        check_value(case_name, exp_value, csr_rdata);
        // The expected mstatus also gives the status output
        if (csr_addr == csr_pkg::CSR_MSTATUS) begin
            check_value(case_name, 64'(status_from_mstatus(exp_value)), 64'(status));
        end
    endtask

    // Cause column holds the interrupt flag in bit 4
    task automatic run_exception_case(input logic [TOKEN_W-1:0] case_name,
                                      input logic [63:0] cause, input logic [63:0] tval,
                                      input logic [63:0] epc, input logic [63:0] exp_value);
        @(posedge clk_i);
        #1;
        drive_idle();
        ex_req.irq  = cause[4];
        ex_req.code = cause[3:0];
        ex_req.tval = tval;
        ex_req.epc  = epc;
        ex_valid    = 1'b1;
        @(negedge clk_i);
        check_value(case_name, exp_value, ex_tvec);
    endtask

    task automatic run_return_case(input logic [TOKEN_W-1:0] case_name,
                                   input logic [63:0] prv, input logic [63:0] exp_value);
        @(posedge clk_i);
        #1;
        drive_idle();
        er_prv   = csr_pkg::priv_lvl_e'(prv[1:0]);
        er_valid = 1'b1;
        @(negedge clk_i);
        check_value(case_name, exp_value, er_epc);
    endtask

    // Interrupt outputs are registered, so look one edge later
    task automatic run_irq_case(input logic [TOKEN_W-1:0] case_name,
                                input logic [63:0] lines, input logic [63:0] exp_value);
        @(posedge clk_i);
        #1;
        drive_idle();
        irq_lines = csr_pkg::irq_lines_t'(lines[3:0]);
        @(posedge clk_i);
        @(negedge clk_i);
        check_value(case_name, exp_value,
                    64'({2'b00, priv_mode, 3'b000, wfi_valid, 3'b000, int_valid, int_cause}));
        // MPRV stays clear in these cases, so loads and stores use the current mode
        check_value(case_name, 64'(exp_value[13:12]), 64'(priv_mode_lsu));
    endtask

    initial begin
        rst_ni    = 1'b0;
        csr_addr  = csr_pkg::CSR_MSTATUS;
        csr_wdata = '0;
        csr_op    = csr_pkg::CSR_OP_READ;
        csr_op_en = 1'b0;
        ex_valid  = 1'b0;
        ex_req    = '0;
        er_valid  = 1'b0;
        er_prv    = csr_pkg::PRIV_LVL_M;
        irq_lines = '0;
        done      = 1'b0;

        fd = $fopen("csr_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the case file csr_cases.txt");
            $display("ERRORS FOUND");
            $fatal(1, "Missing case file");
        end
        line_count = 0;
        while (!$feof(fd)) begin
            n = $fgets(line_buf, fd);
            if (n > 0) begin
                line_count = line_count + 1;
            end
        end
        $fclose(fd);
        cycle_limit = CYCLES_PER_CASE * line_count + 10;
        fd = $fopen("csr_cases.txt", "r");

        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        while (!done) begin
            n = $fscanf(fd, "%s", name);
            if (n != 1) begin
                done = 1'b1;
            end else if (name == TOKEN_W'("#")) begin
                n = $fgets(line_buf, fd);
            end else begin
                n = $fscanf(fd, "%s %h %h %h %h", kind, f1, f2, f3, expected);
                if (n != 5) begin
                    $display("Case %0s has missing or unreadable columns", name);
                    $display("ERRORS FOUND");
                    $fatal(1, "Bad case line");
                end
                if (kind == TOKEN_W'("csr")) begin
                    run_csr_case(name, f1, f2, f3, expected);
                end else if (kind == TOKEN_W'("exception")) begin
                    run_exception_case(name, f1, f2, f3, expected);
                end else if (kind == TOKEN_W'("return")) begin
                    run_return_case(name, f1, expected);
                end else if (kind == TOKEN_W'("irq")) begin
                    run_irq_case(name, f1, expected);
                end else begin
                    $display("Case %0s has an unknown kind %0s", name, kind);
                    $display("ERRORS FOUND");
                    $fatal(1, "Unknown case kind");
                end
            end
        end
        $fclose(fd);

        // Let the last operation commit
        @(posedge clk_i);
        #1;
        drive_idle();

        if (check_count > 0) begin
            $display("%0d checks done", check_count);
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("No checks were run");
            $display("ERRORS FOUND");
            $fatal(1, "Run failed");
        end
    end

endmodule

`default_nettype wire
